/* sim/tb_dsp_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dsp_top
    import dsp_pkg::*;
();

    localparam int RESET_CYCLES   = 10;
    localparam int FLUSH          = CORE_LATENCY + 2;
    localparam int N_WORDS        = 48;
    localparam int N_TESTS        = 6;
    localparam int N_PHASES       = 10;
    localparam int MAX_WRITES     = 10;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_PHASES * (MAX_WRITES + 2 * FLUSH)
                                    + N_TESTS * N_WORDS + 50;

    logic                     clk;
    logic                     rst_n;
    logic                     cfg_wr;
    logic [CFG_ADDR_W-1:0]    cfg_addr;
    logic [CFG_DATA_W-1:0]    cfg_data;
    logic signed [CODE_W-1:0] adc_codes [LANES];
    logic signed [CODE_W-1:0] trunc_ffe [LANES];
    logic [LANES-1:0]         sliced_bits;
    logic signed [EST_W-1:0]  est_codes [LANES];
    logic signed [ERR_W-1:0]  est_errors [LANES];
    sd_flag_e                 sd_flags [LANES];

    logic [31:0] rng_state;
    int          cycle_cnt = 0;
    int          test_checks [N_TESTS];
    int          test_errors [N_TESTS];
    int          flag_count [3];
    string       test_name [N_TESTS];

    // Reference model configuration and history
    int m_w [FFE_TAPS];
    int m_h [CHAN_TAPS];
    int m_ffe_shift;
    int m_thresh;
    int m_chan_shift;
    int m_align;
    int m_adc_prev [LANES];
    bit m_raw_prev [LANES];
    bit m_bits_prev [LANES];

    // Expected output words in arrival order
    logic [LANES*CODE_W-1:0] q_trunc [$];
    logic [LANES-1:0]        q_bits [$];
    logic [LANES*EST_W-1:0]  q_est [$];
    logic [LANES*ERR_W-1:0]  q_err [$];
    logic [2*LANES-1:0]      q_flags [$];
    bit                      q_chk [$];
    int                      q_test [$];

    dsp_top DUT (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .cfg_wr_i      (cfg_wr),
        .cfg_addr_i    (cfg_addr),
        .cfg_data_i    (cfg_data),
        .adc_codes_i   (adc_codes),
        .trunc_ffe_o   (trunc_ffe),
        .sliced_bits_o (sliced_bits),
        .est_codes_o   (est_codes),
        .est_errors_o  (est_errors),
        .sd_flags_o    (sd_flags)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r >> 8) % n;
    endfunction

    function automatic int rand_s8();
        logic [31:0] r;
        r = lcg_next();
        return int'($signed(r[23:16]));
    endfunction

    task automatic check_field(input int t, input string field,
                               input logic [63:0] exp, input logic [63:0] act);
        test_checks[t]++;
        if (exp !== act) begin
            test_errors[t]++;
            $display("[ERROR] %s %s: expected %0h actual %0h", test_name[t], field, exp, act);
        end
    endtask

    task automatic pack_outputs(output logic [LANES*CODE_W-1:0] a_trunc,
                                output logic [LANES*EST_W-1:0] a_est,
                                output logic [LANES*ERR_W-1:0] a_err,
                                output logic [2*LANES-1:0] a_flags);
        for (int i = 0; i < LANES; i++) begin
            a_trunc[CODE_W*i +: CODE_W] = trunc_ffe[i];
            a_est[EST_W*i +: EST_W]     = est_codes[i];
            a_err[ERR_W*i +: ERR_W]     = est_errors[i];
            a_flags[2*i +: 2]           = sd_flags[i];
        end
    endtask

    task automatic check_idle(input int t);
        logic [LANES*CODE_W-1:0] a_trunc;
        logic [LANES*EST_W-1:0]  a_est;
        logic [LANES*ERR_W-1:0]  a_err;
        logic [2*LANES-1:0]      a_flags;
        pack_outputs(a_trunc, a_est, a_err, a_flags);
        check_field(t, "idle trunc_ffe_o", '0, a_trunc);
        check_field(t, "idle sliced_bits_o", '0, sliced_bits);
        check_field(t, "idle est_codes_o", '0, a_est);
        check_field(t, "idle est_errors_o", '0, a_err);
        check_field(t, "idle sd_flags_o", '0, a_flags);
    endtask

    // Outputs for the word driven CORE_LATENCY+1 falling edges ago
    task automatic compare_due(input int t);
        logic [LANES*CODE_W-1:0] a_trunc;
        logic [LANES*EST_W-1:0]  a_est;
        logic [LANES*ERR_W-1:0]  a_err;
        logic [2*LANES-1:0]      a_flags;
        logic [LANES*CODE_W-1:0] e_trunc;
        logic [LANES-1:0]        e_bits;
        logic [LANES*EST_W-1:0]  e_est;
        logic [LANES*ERR_W-1:0]  e_err;
        logic [2*LANES-1:0]      e_flags;
        bit                      cq;
        int                      tq;
        if (q_chk.size() < CORE_LATENCY + 1) begin
            check_idle(t);
        end else begin
            pack_outputs(a_trunc, a_est, a_err, a_flags);
            cq      = q_chk.pop_front();
            tq      = q_test.pop_front();
            e_trunc = q_trunc.pop_front();
            e_bits  = q_bits.pop_front();
            e_est   = q_est.pop_front();
            e_err   = q_err.pop_front();
            e_flags = q_flags.pop_front();
            if (cq) begin
                check_field(tq, "trunc_ffe_o", e_trunc, a_trunc);
                check_field(tq, "sliced_bits_o", e_bits, sliced_bits);
                check_field(tq, "est_codes_o", e_est, a_est);
                check_field(tq, "est_errors_o", e_err, a_err);
                check_field(tq, "sd_flags_o", e_flags, a_flags);
                for (int i = 0; i < LANES; i++) begin
                    if (a_flags[2*i +: 2] < 3) flag_count[a_flags[2*i +: 2]]++;
                end
            end
        end
    endtask

    task automatic update_model_cfg(input cfg_reg_e addr, input int data);
        case (addr)
            CFG_W0:         m_w[0] = data;
            CFG_W1:         m_w[1] = data;
            CFG_W2:         m_w[2] = data;
            CFG_FFE_SHIFT:  m_ffe_shift = data;
            CFG_THRESH:     m_thresh = data;
            CFG_H0:         m_h[0] = data;
            CFG_H1:         m_h[1] = data;
            CFG_H2:         m_h[2] = data;
            CFG_CHAN_SHIFT: m_chan_shift = data;
            CFG_ALIGN:      m_align = data;
            default: begin
            end
        endcase
    endtask

    // One ADC word through every stage rule
    task automatic model_word(input int x [LANES], input bit chk, input int t);
        bit                      raw [LANES];
        bit                      win [2*LANES];
        bit                      bits [LANES];
        int                      y;
        int                      acc;
        int                      s;
        int                      s_prev;
        int                      d0;
        int                      d1;
        int                      r0;
        int                      r1;
        int                      r2;
        int                      best;
        int                      flg;
        int                      est [LANES];
        logic [LANES*CODE_W-1:0] p_trunc;
        logic [LANES-1:0]        p_bits;
        logic [LANES*EST_W-1:0]  p_est;
        logic [LANES*ERR_W-1:0]  p_err;
        logic [2*LANES-1:0]      p_flags;
        for (int i = 0; i < LANES; i++) begin
            acc = 0;
            for (int k = 0; k < FFE_TAPS; k++) begin
                acc += m_w[k] * ((i >= k) ? x[i-k] : m_adc_prev[LANES+i-k]);
            end
            y = acc >>> m_ffe_shift;
            raw[i] = (y > m_thresh);
            p_trunc[CODE_W*i +: CODE_W] = y >>> (FFE_OUT_W - CODE_W);
        end
        for (int j = 0; j < LANES; j++) begin
            win[j]         = m_raw_prev[j];
            win[LANES + j] = raw[j];
        end
        for (int i = 0; i < LANES; i++) begin
            bits[i]   = win[m_align + i];
            p_bits[i] = bits[i];
        end
        for (int i = 0; i < LANES; i++) begin
            acc = 0;
            for (int k = 0; k < CHAN_TAPS; k++) begin
                s = ((i >= k) ? bits[i-k] : m_bits_prev[LANES+i-k]) ? 1 : -1;
                acc += m_h[k] * s;
            end
            est[i] = acc >>> m_chan_shift;
            r0 = est[i] - x[i];
            p_est[EST_W*i +: EST_W] = est[i];
            p_err[ERR_W*i +: ERR_W] = r0;
            s      = bits[i] ? 1 : -1;
            s_prev = ((i == 0) ? m_bits_prev[LANES-1] : bits[i-1]) ? 1 : -1;
            d0 = -2 * s * m_h[0];
            d1 = -2 * s_prev * m_h[1];
            r1 = r0 - d0;
            r2 = r1 - d1;
            // Ties keep the lower flag value
            flg  = 0;
            best = r0 * r0;
            if (r1 * r1 < best) begin
                flg  = 1;
                best = r1 * r1;
            end
            if (r2 * r2 < best) flg = 2;
            p_flags[2*i +: 2] = flg;
        end
        m_adc_prev  = x;
        m_raw_prev  = raw;
        m_bits_prev = bits;
        q_trunc.push_back(p_trunc);
        q_bits.push_back(p_bits);
        q_est.push_back(p_est);
        q_err.push_back(p_err);
        q_flags.push_back(p_flags);
        q_chk.push_back(chk);
        q_test.push_back(t);
    endtask

    task automatic step(input int t, input bit chk, input bit wr,
                        input cfg_reg_e addr, input int data);
        int x [LANES];
        @(negedge clk);
        compare_due(t);
        for (int i = 0; i < LANES; i++) begin
            x[i]         = rand_s8();
            adc_codes[i] = x[i];
        end
        cfg_wr   = wr;
        cfg_addr = addr;
        cfg_data = data;
        if (wr) update_model_cfg(addr, data);
        model_word(x, chk, t);
    endtask

    task automatic write_cfg(input int t, input cfg_reg_e addr, input int data);
        step(t, 1'b0, 1'b1, addr, data);
    endtask

    task automatic run_words(input int t, input int n);
        repeat (FLUSH) step(t, 1'b0, 1'b0, CFG_W0, 0);
        repeat (n) step(t, 1'b1, 1'b0, CFG_W0, 0);
        repeat (FLUSH) step(t, 1'b0, 1'b0, CFG_W0, 0);
    endtask

    task automatic report_test(input int t);
        $display("test %-9s %4d checks %3d errors  %s", test_name[t], test_checks[t],
                 test_errors[t], (test_errors[t] == 0) ? "ok" : "FAIL");
    endtask

    initial begin
        int total_checks;
        int total_errors;
        int failed_tests;
        rng_state = 32'h2262;
        rst_n     = 1'b0;
        cfg_wr    = 1'b0;
        cfg_addr  = '0;
        cfg_data  = '0;
        for (int i = 0; i < LANES; i++) begin
            adc_codes[i]   = '0;
            m_adc_prev[i]  = 0;
            m_raw_prev[i]  = 1'b0;
            m_bits_prev[i] = 1'b0;
        end
        m_w          = '{default: 0};
        m_h          = '{default: 0};
        m_ffe_shift  = 0;
        m_thresh     = 0;
        m_chan_shift = 0;
        m_align      = 0;
        test_checks  = '{default: 0};
        test_errors  = '{default: 0};
        flag_count   = '{default: 0};
        test_name    = '{"reset", "ffe", "slicer", "aligner", "channel", "detector"};

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle(0);
        end
        rst_n = 1'b1;
        run_words(0, N_WORDS);
        report_test(0);

        write_cfg(1, CFG_W0, rand_s8());
        write_cfg(1, CFG_W1, rand_s8());
        write_cfg(1, CFG_W2, rand_s8());
        write_cfg(1, CFG_FFE_SHIFT, rand_below(8));
        run_words(1, N_WORDS);
        report_test(1);

        // One negative and one positive threshold
        write_cfg(2, CFG_FFE_SHIFT, 4);
        write_cfg(2, CFG_ALIGN, 0);
        write_cfg(2, CFG_THRESH, -(1 + rand_below(512)));
        run_words(2, N_WORDS / 2);
        write_cfg(2, CFG_THRESH, rand_below(512));
        run_words(2, N_WORDS / 2);
        report_test(2);

        for (int a = 0; a < LANES; a++) begin
            write_cfg(3, CFG_ALIGN, a);
            run_words(3, N_WORDS / LANES);
        end
        report_test(3);

        write_cfg(4, CFG_H0, rand_s8());
        write_cfg(4, CFG_H1, rand_s8());
        write_cfg(4, CFG_H2, rand_s8());
        write_cfg(4, CFG_CHAN_SHIFT, rand_below(4));
        run_words(4, N_WORDS);
        report_test(4);

        // Bits track the code sign and the taps are sized so every flag can win
        write_cfg(5, CFG_W0, 1);
        write_cfg(5, CFG_W1, 0);
        write_cfg(5, CFG_W2, 0);
        write_cfg(5, CFG_FFE_SHIFT, 0);
        write_cfg(5, CFG_THRESH, 0);
        write_cfg(5, CFG_ALIGN, 0);
        write_cfg(5, CFG_H0, 40 + rand_below(16));
        write_cfg(5, CFG_H1, 24 + rand_below(16));
        write_cfg(5, CFG_H2, rand_below(16) - 8);
        write_cfg(5, CFG_CHAN_SHIFT, 0);
        flag_count = '{default: 0};
        run_words(5, N_WORDS);
        for (int f = 0; f < 3; f++) begin
            if (flag_count[f] == 0) begin
                test_errors[5]++;
                $display("Detector flag value %0d never occurred during the detector test", f);
            end
        end
        report_test(5);

        total_checks = 0;
        total_errors = 0;
        failed_tests = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            total_checks += test_checks[t];
            total_errors += test_errors[t];
            if (test_errors[t] != 0) failed_tests++;
        end
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 N_TESTS, failed_tests, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/channel_filter.sv */
`timescale 1ns/1ns
`default_nettype none

module channel_filter
    import dsp_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic [LANES-1:0]          bits_i,
    input  logic signed [CHAN_W-1:0]  taps_i [CHAN_TAPS],
    input  logic [SHIFT_W-1:0]        shift_i,
    output logic signed [EST_W-1:0]   est_o [LANES]
);

    logic [LANES-1:0]        bits_prev;
    logic [2*LANES-1:0]      window;
    logic signed [EST_W-1:0] tap_x [CHAN_TAPS];
    logic signed [EST_W-1:0] acc [LANES];

    assign window = {bits_i, bits_prev};

    // Bit 1 adds the tap, bit 0 subtracts it
    always_comb begin
        for (int k = 0; k < CHAN_TAPS; k++) begin
            tap_x[k] = taps_i[k];
        end
        for (int i = 0; i < LANES; i++) begin
            acc[i] = '0;
            for (int k = 0; k < CHAN_TAPS; k++) begin
                if (window[LANES + i - k]) begin
                    acc[i] = acc[i] + tap_x[k];
                end else begin
                    acc[i] = acc[i] - tap_x[k];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            bits_prev <= '0;
            est_o     <= '{default: '0};
        end else begin
            bits_prev <= bits_i;
            for (int i = 0; i < LANES; i++) begin
                est_o[i] <= acc[i] >>> shift_i;
            end
        end
    end

endmodule

`default_nettype wire

/* source/datapath_core.sv */
`timescale 1ns/1ns
`default_nettype none

module datapath_core
    import dsp_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic signed [CODE_W-1:0]   adc_codes_i [LANES],
    input  logic signed [WEIGHT_W-1:0] weights_i [FFE_TAPS],
    input  logic [SHIFT_W-1:0]         ffe_shift_i,
    input  logic signed [THRESH_W-1:0] thresh_i,
    input  logic signed [CHAN_W-1:0]   chan_taps_i [CHAN_TAPS],
    input  logic [SHIFT_W-1:0]         chan_shift_i,
    input  logic [ALIGN_W-1:0]         align_pos_i,
    output logic signed [CODE_W-1:0]   trunc_ffe_o [LANES],
    output logic [LANES-1:0]           sliced_bits_o,
    output logic signed [EST_W-1:0]    est_codes_o [LANES],
    output logic signed [ERR_W-1:0]    est_errors_o [LANES],
    output sd_flag_e                   sd_flags_o [LANES]
);

    logic signed [CODE_W-1:0]    adc_q [LANES];
    logic signed [CODE_W-1:0]    adc_dly [ADC_DLY][LANES];
    logic signed [FFE_OUT_W-1:0] ffe_out [LANES];
    logic signed [CODE_W-1:0]    ffe_trunc [LANES];
    logic signed [CODE_W-1:0]    ffe_dly [FFE_DLY][LANES];
    logic [LANES-1:0]            aligned_bits;
    logic [LANES-1:0]            bits_dly [BITS_DLY];
    logic signed [EST_W-1:0]     est [LANES];
    logic signed [EST_W-1:0]     est_dly [EST_DLY][LANES];
    logic signed [ERR_W-1:0]     err [LANES];
    logic signed [ERR_W-1:0]     err_dly [ERR_DLY][LANES];

    always_comb begin
        logic signed [FFE_OUT_W-1:0] sh;
        for (int i = 0; i < LANES; i++) begin
            sh           = ffe_out[i] >>> TRUNC_SHIFT;
            ffe_trunc[i] = sh[CODE_W-1:0];
        end
    end

    // Input register plus the delay lines that bring every result to E+6
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            adc_q    <= '{default: '0};
            adc_dly  <= '{default: '0};
            ffe_dly  <= '{default: '0};
            bits_dly <= '{default: '0};
            est_dly  <= '{default: '0};
            err_dly  <= '{default: '0};
        end else begin
            adc_q       <= adc_codes_i;
            adc_dly[0]  <= adc_q;
            ffe_dly[0]  <= ffe_trunc;
            bits_dly[0] <= aligned_bits;
            est_dly[0]  <= est;
            err_dly[0]  <= err;
            for (int d = 1; d < ADC_DLY; d++) adc_dly[d] <= adc_dly[d-1];
            for (int d = 1; d < FFE_DLY; d++) ffe_dly[d] <= ffe_dly[d-1];
            for (int d = 1; d < BITS_DLY; d++) bits_dly[d] <= bits_dly[d-1];
            for (int d = 1; d < EST_DLY; d++) est_dly[d] <= est_dly[d-1];
            for (int d = 1; d < ERR_DLY; d++) err_dly[d] <= err_dly[d-1];
        end
    end

    ffe_filter u_ffe (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .codes_i   (adc_q),
        .weights_i (weights_i),
        .shift_i   (ffe_shift_i),
        .ffe_o     (ffe_out)
    );

    slicer_aligner u_slicer (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ffe_i       (ffe_out),
        .thresh_i    (thresh_i),
        .align_pos_i (align_pos_i),
        .bits_o      (aligned_bits)
    );

    channel_filter u_chan (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bits_i  (aligned_bits),
        .taps_i  (chan_taps_i),
        .shift_i (chan_shift_i),
        .est_o   (est)
    );

    // ADC word at E+4 pairs with the estimate built from its own bits
    error_detector u_err (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .est_i   (est),
        .codes_i (adc_dly[ADC_DLY-1]),
        .bits_i  (bits_dly[0]),
        .taps_i  (chan_taps_i),
        .err_o   (err),
        .flags_o (sd_flags_o)
    );

    assign trunc_ffe_o   = ffe_dly[FFE_DLY-1];
    assign sliced_bits_o = bits_dly[BITS_DLY-1];
    assign est_codes_o   = est_dly[EST_DLY-1];
    assign est_errors_o  = err_dly[ERR_DLY-1];

endmodule

`default_nettype wire

/* source/dsp_cfg_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module dsp_cfg_regs
    import dsp_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       cfg_wr_i,
    input  logic [CFG_ADDR_W-1:0]      cfg_addr_i,
    input  logic [CFG_DATA_W-1:0]      cfg_data_i,
    output logic signed [WEIGHT_W-1:0] weights_o [FFE_TAPS],
    output logic [SHIFT_W-1:0]         ffe_shift_o,
    output logic signed [THRESH_W-1:0] thresh_o,
    output logic signed [CHAN_W-1:0]   chan_taps_o [CHAN_TAPS],
    output logic [SHIFT_W-1:0]         chan_shift_o,
    output logic [ALIGN_W-1:0]         align_pos_o
);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            weights_o    <= '{default: '0};
            ffe_shift_o  <= '0;
            thresh_o     <= '0;
            chan_taps_o  <= '{default: '0};
            chan_shift_o <= '0;
            align_pos_o  <= '0;
        end else if (cfg_wr_i) begin
            // Each field keeps the low bits of the data word
            case (cfg_reg_e'(cfg_addr_i))
                CFG_W0:         weights_o[0]   <= cfg_data_i[WEIGHT_W-1:0];
                CFG_W1:         weights_o[1]   <= cfg_data_i[WEIGHT_W-1:0];
                CFG_W2:         weights_o[2]   <= cfg_data_i[WEIGHT_W-1:0];
                CFG_FFE_SHIFT:  ffe_shift_o    <= cfg_data_i[SHIFT_W-1:0];
                CFG_THRESH:     thresh_o       <= cfg_data_i[THRESH_W-1:0];
                CFG_H0:         chan_taps_o[0] <= cfg_data_i[CHAN_W-1:0];
                CFG_H1:         chan_taps_o[1] <= cfg_data_i[CHAN_W-1:0];
                CFG_H2:         chan_taps_o[2] <= cfg_data_i[CHAN_W-1:0];
                CFG_CHAN_SHIFT: chan_shift_o   <= cfg_data_i[SHIFT_W-1:0];
                CFG_ALIGN:      align_pos_o    <= cfg_data_i[ALIGN_W-1:0];
                default: begin
                end
            endcase
        end
    end

    // Aligner window is only two words wide
    a_align_write_range: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (cfg_wr_i && cfg_addr_i == CFG_ALIGN) |-> (cfg_data_i < LANES)
    ) else $error("align position write out of range");

endmodule

`default_nettype wire

/* source/dsp_pkg.sv */
`default_nettype none

package dsp_pkg;

    // Word geometry
    localparam int LANES   = 4;
    localparam int CODE_W  = 8;
    localparam int ALIGN_W = 2;

    // Feed-forward equalizer
    localparam int FFE_TAPS    = 3;
    localparam int WEIGHT_W    = 8;
    localparam int FFE_OUT_W   = 18;
    localparam int SHIFT_W     = 4;
    localparam int TRUNC_SHIFT = FFE_OUT_W - CODE_W;
    localparam int THRESH_W    = 18;

    // Channel estimate and error
    localparam int CHAN_TAPS = 3;
    localparam int CHAN_W    = 8;
    localparam int EST_W     = 10;
    localparam int ERR_W     = 11;
    localparam int DET_RES_W = ERR_W + 2;
    localparam int DET_SQ_W  = 2 * DET_RES_W;

    localparam int CFG_ADDR_W = 4;
    localparam int CFG_DATA_W = 18;

    // Pipeline depths counted from the ADC input register
    localparam int CORE_LATENCY = 6;
    localparam int ADC_DLY      = CORE_LATENCY - 2;
    localparam int FFE_DLY      = CORE_LATENCY - 1;
    localparam int BITS_DLY     = CORE_LATENCY - 3;
    localparam int EST_DLY      = CORE_LATENCY - 4;
    localparam int ERR_DLY      = CORE_LATENCY - 5;

    typedef enum logic [CFG_ADDR_W-1:0] {
        CFG_W0         = 4'd0,
        CFG_W1         = 4'd1,
        CFG_W2         = 4'd2,
        CFG_FFE_SHIFT  = 4'd3,
        CFG_THRESH     = 4'd4,
        CFG_H0         = 4'd5,
        CFG_H1         = 4'd6,
        CFG_H2         = 4'd7,
        CFG_CHAN_SHIFT = 4'd8,
        CFG_ALIGN      = 4'd9
    } cfg_reg_e;

    typedef enum logic [1:0] {
        SD_NONE      = 2'd0,
        SD_FLIP_CUR  = 2'd1,
        SD_FLIP_PAIR = 2'd2
    } sd_flag_e;

endpackage

`default_nettype wire

/* source/dsp_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dsp_top
    import dsp_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      cfg_wr_i,
    input  logic [CFG_ADDR_W-1:0]     cfg_addr_i,
    input  logic [CFG_DATA_W-1:0]     cfg_data_i,
    input  logic signed [CODE_W-1:0]  adc_codes_i [LANES],
    output logic signed [CODE_W-1:0]  trunc_ffe_o [LANES],
    output logic [LANES-1:0]          sliced_bits_o,
    output logic signed [EST_W-1:0]   est_codes_o [LANES],
    output logic signed [ERR_W-1:0]   est_errors_o [LANES],
    output sd_flag_e                  sd_flags_o [LANES]
);

    logic signed [WEIGHT_W-1:0] weights [FFE_TAPS];
    logic [SHIFT_W-1:0]         ffe_shift;
    logic signed [THRESH_W-1:0] thresh;
    logic signed [CHAN_W-1:0]   chan_taps [CHAN_TAPS];
    logic [SHIFT_W-1:0]         chan_shift;
    logic [ALIGN_W-1:0]         align_pos;

    dsp_cfg_regs u_cfg (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .cfg_wr_i     (cfg_wr_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_data_i   (cfg_data_i),
        .weights_o    (weights),
        .ffe_shift_o  (ffe_shift),
        .thresh_o     (thresh),
        .chan_taps_o  (chan_taps),
        .chan_shift_o (chan_shift),
        .align_pos_o  (align_pos)
    );

    datapath_core u_core (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .adc_codes_i   (adc_codes_i),
        .weights_i     (weights),
        .ffe_shift_i   (ffe_shift),
        .thresh_i      (thresh),
        .chan_taps_i   (chan_taps),
        .chan_shift_i  (chan_shift),
        .align_pos_i   (align_pos),
        .trunc_ffe_o   (trunc_ffe_o),
        .sliced_bits_o (sliced_bits_o),
        .est_codes_o   (est_codes_o),
        .est_errors_o  (est_errors_o),
        .sd_flags_o    (sd_flags_o)
    );

endmodule

`default_nettype wire

/* source/error_detector.sv */
`timescale 1ns/1ns
`default_nettype none

module error_detector
    import dsp_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic signed [EST_W-1:0]   est_i [LANES],
    input  logic signed [CODE_W-1:0]  codes_i [LANES],
    input  logic [LANES-1:0]          bits_i,
    input  logic signed [CHAN_W-1:0]  taps_i [CHAN_TAPS],
    output logic signed [ERR_W-1:0]   err_o [LANES],
    output sd_flag_e                  flags_o [LANES]
);

    logic [LANES-1:0]            bits_d;
    logic                        last_bit;
    logic signed [DET_RES_W-1:0] h0_x2;
    logic signed [DET_RES_W-1:0] h1_x2;
    sd_flag_e                    flag_next [LANES];

    // Bits held one stage so they line up with err_o
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            err_o    <= '{default: '0};
            bits_d   <= '0;
            last_bit <= 1'b0;
        end else begin
            for (int i = 0; i < LANES; i++) begin
                err_o[i] <= est_i[i] - codes_i[i];
            end
            bits_d   <= bits_i;
            last_bit <= bits_d[LANES-1];
        end
    end

    assign h0_x2 = taps_i[0] + taps_i[0];
    assign h1_x2 = taps_i[1] + taps_i[1];

    always_comb begin
        logic                        s_prev;
        logic signed [DET_RES_W-1:0] d0;
        logic signed [DET_RES_W-1:0] d1;
        logic signed [DET_RES_W-1:0] r0;
        logic signed [DET_RES_W-1:0] r1;
        logic signed [DET_RES_W-1:0] r2;
        logic signed [DET_SQ_W-1:0]  best;
        for (int i = 0; i < LANES; i++) begin
            s_prev = (i == 0) ? last_bit : bits_d[i-1];
            // Flipping a +1 decision changes the estimate by -2h
            d0 = bits_d[i] ? -h0_x2 : h0_x2;
            d1 = s_prev ? -h1_x2 : h1_x2;
            r0 = err_o[i];
            r1 = r0 - d0;
            r2 = r1 - d1;
            flag_next[i] = SD_NONE;
            best = r0 * r0;
            if (r1 * r1 < best) begin
                flag_next[i] = SD_FLIP_CUR;
                best = r1 * r1;
            end
            if (r2 * r2 < best) begin
                flag_next[i] = SD_FLIP_PAIR;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            flags_o <= '{default: SD_NONE};
        end else begin
            flags_o <= flag_next;
        end
    end

    for (genvar gi = 0; gi < LANES; gi++) begin : g_flag_chk
        a_flag_legal: assert property (
            @(posedge clk) disable iff (!rst_n_i)
            flags_o[gi] != 2'b11
        ) else $error("detector flag lane %0d holds unused encoding", gi);
    end

endmodule

`default_nettype wire

/* source/ffe_filter.sv */
`timescale 1ns/1ns
`default_nettype none

module ffe_filter
    import dsp_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic signed [CODE_W-1:0]    codes_i [LANES],
    input  logic signed [WEIGHT_W-1:0]  weights_i [FFE_TAPS],
    input  logic [SHIFT_W-1:0]          shift_i,
    output logic signed [FFE_OUT_W-1:0] ffe_o [LANES]
);

    logic signed [CODE_W-1:0]    codes_prev [LANES];
    logic signed [CODE_W-1:0]    window [2*LANES];
    logic signed [FFE_OUT_W-1:0] acc [LANES];

    // Previous word first, so lane i of the current word sits at LANES+i
    always_comb begin
        for (int j = 0; j < LANES; j++) begin
            window[j]         = codes_prev[j];
            window[LANES + j] = codes_i[j];
        end
    end

    // Products are sign extended to the full sum width
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            acc[i] = '0;
            for (int k = 0; k < FFE_TAPS; k++) begin
                acc[i] = acc[i] + window[LANES + i - k] * weights_i[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            codes_prev <= '{default: '0};
            ffe_o      <= '{default: '0};
        end else begin
            codes_prev <= codes_i;
            for (int i = 0; i < LANES; i++) begin
                ffe_o[i] <= acc[i] >>> shift_i;
            end
        end
    end

endmodule

`default_nettype wire

/* source/slicer_aligner.sv */
`timescale 1ns/1ns
`default_nettype none

module slicer_aligner
    import dsp_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic signed [FFE_OUT_W-1:0] ffe_i [LANES],
    input  logic signed [THRESH_W-1:0]  thresh_i,
    input  logic [ALIGN_W-1:0]          align_pos_i,
    output logic [LANES-1:0]            bits_o
);

    logic [LANES-1:0]   raw;
    logic [LANES-1:0]   raw_prev;
    logic [2*LANES-1:0] window;

    // Bit 0 of the window is the earliest sample of the older word
    assign window = {raw, raw_prev};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            raw      <= '0;
            raw_prev <= '0;
            bits_o   <= '0;
        end else begin
            for (int i = 0; i < LANES; i++) begin
                raw[i] <= (ffe_i[i] > thresh_i);
            end
            raw_prev <= raw;
            bits_o   <= window[align_pos_i +: LANES];
        end
    end

    a_align_pos_range: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        int'(align_pos_i) < LANES
    ) else $error("align position outside the two-word window");

endmodule

`default_nettype wire

/* src.f */
source/dsp_pkg.sv
source/dsp_cfg_regs.sv
source/ffe_filter.sv
source/slicer_aligner.sv
source/channel_filter.sv
source/error_detector.sv
source/datapath_core.sv
source/dsp_top.sv
sim/tb_dsp_top.sv
